/* Makefile */
VERILATOR ?= verilator
TOP       ?= rob_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
logic/rob_pkg.sv
logic/dispatch_if.sv
logic/cdb_if.sv
logic/rob_control.sv
logic/rob_entry_store.sv
logic/rename_table.sv
logic/rob_top.sv
testbench/rob_tb_clock.sv
testbench/rob_assert.sv
testbench/rob_tb.sv

/* logic/cdb_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface cdb_if;
    import rob_pkg::*;

    // one strobe per writeback port, no back-pressure
    logic [issue_width-1:0] valid;

    // entry being completed
    rob_id_t                rob_id [issue_width];

    // result carried to the entry
    data_t                  value  [issue_width];

    // entry store consumes both ports
    modport sink (input valid, input rob_id, input value);

endinterface

`default_nettype wire

/* logic/dispatch_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface dispatch_if;
    import rob_pkg::*;

    // request side, driven from the top inputs
    logic [issue_width-1:0] valid;
    arch_reg_t              rd  [issue_width];
    arch_reg_t              rs1 [issue_width];

    // grant side, driven by the control block
    logic [issue_width-1:0] accept;
    rob_id_t                id  [issue_width];

    // control decides acceptance and hands out ids
    modport ctrl (input valid, output accept, output id);

    // entry store writes rd into the allocated slots
    modport store (input accept, input id, input rd);

    // rename table looks up rs1 and records rd producers
    modport rename (input accept, input id, input rd, input rs1);

endinterface

`default_nettype wire

/* logic/rename_table.sv */
`timescale 1ns/10ps
`default_nettype none

module rename_table (
    input  logic              clk,
    input  logic              rst,
    dispatch_if.rename        disp,
    input  logic [rob_pkg::issue_width-1:0] commit_valid,
    input  rob_pkg::rob_id_t  commit_id  [rob_pkg::issue_width],
    input  rob_pkg::arch_reg_t commit_rd [rob_pkg::issue_width],
    output rob_pkg::rob_id_t  src_tag    [rob_pkg::issue_width],
    output logic [rob_pkg::issue_width-1:0] src_busy
);
    import rob_pkg::*;

    // register has an in-flight writer
    logic [31:0] busy;
    // rob id of the youngest writer
    rob_id_t     tag [32];

    // rs1 lookup
    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            src_tag[i] = tag[disp.rs1[i]];
            src_busy[i] = busy[disp.rs1[i]];
            // an older slot in the same group writing rs1 is the real producer
            for (int k = 0; k < i; k++) begin
                if (disp.accept[k] && disp.rd[k] != '0 && disp.rd[k] == disp.rs1[i]) begin
                    src_tag[i] = disp.id[k];
                    src_busy[i] = 1'b1;
                end
            end
        end
    end

    // busy flags
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            // clear only if the committing entry is still the youngest writer
            for (int i = 0; i < issue_width; i++) begin
                if (commit_valid[i] && tag[commit_rd[i]] == commit_id[i]) begin
                    busy[commit_rd[i]] <= 1'b0;
                end
            end
            // later assignment wins, so dispatch beats the clear and slot 1 beats slot 0
            // x0 is never marked
            for (int i = 0; i < issue_width; i++) begin
                if (disp.accept[i] && disp.rd[i] != '0) begin
                    busy[disp.rd[i]] <= 1'b1;
                end
            end
        end
    end

    // producer ids
    always_ff @(posedge clk) begin
        for (int i = 0; i < issue_width; i++) begin
            if (disp.accept[i] && disp.rd[i] != '0) begin
                tag[disp.rd[i]] <= disp.id[i];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/rob_control.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_control (
    input  logic                clk,
    input  logic                rst,
    dispatch_if.ctrl            disp,
    input  rob_pkg::rob_entry_t head_entry    [rob_pkg::issue_width],
    input  logic [rob_pkg::issue_width-1:0] head_occupied,
    input  logic                commit_ready,
    output rob_pkg::rob_id_t    head,
    output logic [rob_pkg::issue_width-1:0] commit_valid,
    output logic                dispatch_ready,
    output logic                empty
);
    import rob_pkg::*;

    // oldest entry
    rob_id_t head_q;
    // next free entry
    rob_id_t tail_q;
    // entries in flight
    count_t  count;

    // entries entering and leaving this cycle
    count_t  num_push;
    count_t  num_pop;

    assign head = head_q;
    assign empty = (count == '0);

    // a whole group needs issue_width free entries
    assign dispatch_ready = (count <= count_t'(rob_depth - issue_width));

    // acceptance and id hand-out
    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            disp.accept[i] = disp.valid[i] && dispatch_ready;
            // ids run on from the tail, wrapping at the depth
            disp.id[i] = tail_q + rob_id_t'(i);
        end
    end

    // in-order commit
    // slot 0 needs an occupied, done head and a ready core
    // each later slot also needs every older slot to commit
    always_comb begin
        commit_valid[0] = commit_ready && head_occupied[0] && head_entry[0].done;
        for (int i = 1; i < issue_width; i++) begin
            commit_valid[i] = commit_valid[i-1] && head_occupied[i] && head_entry[i].done;
        end
    end

    // count pushes and pops
    always_comb begin
        num_push = '0;
        num_pop = '0;
        for (int i = 0; i < issue_width; i++) begin
            num_push = num_push + count_t'(disp.accept[i]);
            num_pop = num_pop + count_t'(commit_valid[i]);
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            count <= '0;
        end else begin
            head_q <= head_q + rob_id_t'(num_pop);
            tail_q <= tail_q + rob_id_t'(num_push);
            // both can happen in the same cycle
            count <= count + num_push - num_pop;
        end
    end

endmodule

`default_nettype wire

/* logic/rob_entry_store.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_entry_store (
    input  logic                clk,
    input  logic                rst,
    dispatch_if.store           disp,
    cdb_if.sink                 cdb,
    input  rob_pkg::rob_id_t    head,
    input  logic [rob_pkg::issue_width-1:0] commit_valid,
    output rob_pkg::rob_entry_t head_entry    [rob_pkg::issue_width],
    output logic [rob_pkg::issue_width-1:0] head_occupied
);
    import rob_pkg::*;

    // entry array
    rob_entry_t             entries [rob_depth];
    // one bit per allocated entry
    logic [rob_depth-1:0]   occupied;

    // entry payload
    always_ff @(posedge clk) begin
        // dispatch opens a fresh entry, not yet done
        for (int i = 0; i < issue_width; i++) begin
            if (disp.accept[i]) begin
                entries[disp.id[i]].rd <= disp.rd[i];
                entries[disp.id[i]].done <= 1'b0;
            end
        end
        // writeback completes an allocated entry
        for (int j = 0; j < issue_width; j++) begin
            if (cdb.valid[j]) begin
                entries[cdb.rob_id[j]].done <= 1'b1;
                entries[cdb.rob_id[j]].value <= cdb.value[j];
            end
        end
    end

    // allocation bits
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
        end else begin
            // dispatch only targets free entries, so it never meets a commit
            for (int i = 0; i < issue_width; i++) begin
                if (disp.accept[i]) begin
                    occupied[disp.id[i]] <= 1'b1;
                end
                if (commit_valid[i]) begin
                    occupied[head + rob_id_t'(i)] <= 1'b0;
                end
            end
        end
    end

    // head window read
    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            head_entry[i] = entries[head + rob_id_t'(i)];
            head_occupied[i] = occupied[head + rob_id_t'(i)];
        end
    end

endmodule

`default_nettype wire

/* logic/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // slots per cycle for dispatch, writeback and commit
    localparam int issue_width = 2;

    // number of reorder buffer entries
    localparam int rob_depth = 8;

    // width of a rob id
    localparam int rob_id_w = $clog2(rob_depth);

    typedef logic [rob_id_w-1:0] rob_id_t;

    // rv32i architectural register number
    typedef logic [4:0] arch_reg_t;

    // result word
    typedef logic [31:0] data_t;

    // one rob entry
    // done is set by writeback, rd comes from dispatch
    typedef struct packed {
        logic      done;
        arch_reg_t rd;
        data_t     value;
    } rob_entry_t;

    // occupancy needs one extra bit so that a full rob can be told apart from empty
    typedef logic [rob_id_w:0] count_t;

endpackage

`default_nettype wire

/* logic/rob_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_top (
    input  logic                clk,
    input  logic                rst,
    // dispatch group
    input  logic [rob_pkg::issue_width-1:0] disp_valid,
    input  rob_pkg::arch_reg_t  disp_rd      [rob_pkg::issue_width],
    input  rob_pkg::arch_reg_t  disp_rs1     [rob_pkg::issue_width],
    output logic                dispatch_ready,
    output rob_pkg::rob_id_t    disp_id      [rob_pkg::issue_width],
    output rob_pkg::rob_id_t    src_tag      [rob_pkg::issue_width],
    output logic [rob_pkg::issue_width-1:0] src_busy,
    // writeback ports
    input  logic [rob_pkg::issue_width-1:0] wb_valid,
    input  rob_pkg::rob_id_t    wb_id        [rob_pkg::issue_width],
    input  rob_pkg::data_t      wb_value     [rob_pkg::issue_width],
    // commit
    input  logic                commit_ready,
    output logic [rob_pkg::issue_width-1:0] commit_valid,
    output rob_pkg::rob_id_t    commit_id    [rob_pkg::issue_width],
    output rob_pkg::arch_reg_t  commit_rd    [rob_pkg::issue_width],
    output rob_pkg::data_t      commit_value [rob_pkg::issue_width],
    output logic                empty
);
    import rob_pkg::*;

    dispatch_if disp_bus ();
    cdb_if      cdb_bus ();

    // head window shared by the store and control
    rob_entry_t             head_entry [issue_width];
    logic [issue_width-1:0] head_occupied;
    rob_id_t                head;

    // dispatch requests in, ids out
    assign disp_bus.valid = disp_valid;
    assign disp_bus.rd = disp_rd;
    assign disp_bus.rs1 = disp_rs1;
    assign disp_id = disp_bus.id;

    // writeback straight onto the bus
    assign cdb_bus.valid = wb_valid;
    assign cdb_bus.rob_id = wb_id;
    assign cdb_bus.value = wb_value;

    // commit fields taken from the head window
    for (genvar i = 0; i < issue_width; i++) begin : g_commit
        assign commit_id[i] = head + rob_id_t'(i);
        assign commit_rd[i] = head_entry[i].rd;
        assign commit_value[i] = head_entry[i].value;
    end

    rob_control rob_control_i (
        .clk            (clk),
        .rst            (rst),
        .disp           (disp_bus.ctrl),
        .head_entry     (head_entry),
        .head_occupied  (head_occupied),
        .commit_ready   (commit_ready),
        .head           (head),
        .commit_valid   (commit_valid),
        .dispatch_ready (dispatch_ready),
        .empty          (empty)
    );

    rob_entry_store rob_entry_store_i (
        .clk            (clk),
        .rst            (rst),
        .disp           (disp_bus.store),
        .cdb            (cdb_bus.sink),
        .head           (head),
        .commit_valid   (commit_valid),
        .head_entry     (head_entry),
        .head_occupied  (head_occupied)
    );

    rename_table rename_table_i (
        .clk            (clk),
        .rst            (rst),
        .disp           (disp_bus.rename),
        .commit_valid   (commit_valid),
        .commit_id      (commit_id),
        .commit_rd      (commit_rd),
        .src_tag        (src_tag),
        .src_busy       (src_busy)
    );

endmodule

`default_nettype wire

/* testbench/rob_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_assert (
    input  logic                            clk,
    input  logic                            rst,
    input  rob_pkg::count_t                 count,
    input  logic [rob_pkg::issue_width-1:0] commit_valid,
    input  logic [rob_pkg::issue_width-1:0] accept,
    input  logic                            dispatch_ready
);
    import rob_pkg::*;

    // occupancy bounded by the array size
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= count_t'(rob_depth))
        else $error("rob occupancy above depth");

    // in-order retire, slot 1 only behind slot 0
    a_commit_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid[1] |-> commit_valid[0])
        else $error("slot 1 committed without slot 0");

    // no allocation while the rob lacks room for a group
    a_accept_ready: assert property (@(posedge clk) disable iff (rst)
        !dispatch_ready |-> (accept == '0))
        else $error("dispatch accepted while not ready");

    // empty rob after reset retires nothing
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (commit_valid == '0))
        else $error("commit valid right after reset");

endmodule

bind rob_control rob_assert rob_assert_i (
    .clk            (clk),
    .rst            (rst),
    .count          (count),
    .commit_valid   (commit_valid),
    .accept         (disp.accept),
    .dispatch_ready (dispatch_ready)
);

`default_nettype wire

/* testbench/rob_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_tb;
    import rob_pkg::*;

    // one table row holds a dispatch group, writeback strobes and commit_ready
    typedef struct packed {
        logic [1:0] dv;
        arch_reg_t  rd0;
        arch_reg_t  rs0;
        arch_reg_t  rd1;
        arch_reg_t  rs1;
        logic [1:0] wv;
        rob_id_t    w0;
        rob_id_t    w1;
        data_t      v0;
        data_t      v1;
        logic       cr;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [issue_width-1:0] disp_valid;
    arch_reg_t              disp_rd      [issue_width];
    arch_reg_t              disp_rs1     [issue_width];
    logic                   dispatch_ready;
    rob_id_t                disp_id      [issue_width];
    rob_id_t                src_tag      [issue_width];
    logic [issue_width-1:0] src_busy;
    logic [issue_width-1:0] wb_valid;
    rob_id_t                wb_id        [issue_width];
    data_t                  wb_value     [issue_width];
    logic                   commit_ready;
    logic [issue_width-1:0] commit_valid;
    rob_id_t                commit_id    [issue_width];
    arch_reg_t              commit_rd    [issue_width];
    data_t                  commit_value [issue_width];
    logic                   empty;

    row_t    rows  [$];
    string   names [$];
    // reference model with in-flight ids in program order, per-id state and the producer map
    rob_id_t q [$];
    rob_id_t m_tail;
    bit      m_done  [rob_depth];
    arch_reg_t m_rd  [rob_depth];
    data_t   m_value [rob_depth];
    bit      m_busy  [32];
    rob_id_t m_tag   [32];
    int      cycles;
    int      cycle_limit;

    rob_tb_clock clock_gen (.clk(clk));

    rob_top rob_top_i (
        .clk(clk), .rst(rst),
        .disp_valid(disp_valid), .disp_rd(disp_rd), .disp_rs1(disp_rs1),
        .dispatch_ready(dispatch_ready), .disp_id(disp_id),
        .src_tag(src_tag), .src_busy(src_busy),
        .wb_valid(wb_valid), .wb_id(wb_id), .wb_value(wb_value),
        .commit_ready(commit_ready), .commit_valid(commit_valid),
        .commit_id(commit_id), .commit_rd(commit_rd),
        .commit_value(commit_value), .empty(empty)
    );

    task automatic fail_now(input string why);
        $display("CHECKS FAILED");
        $fatal(1, why);
    endtask

    task automatic check_id(input string name, input rob_id_t exp, input rob_id_t act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            fail_now("rob id mismatch");
        end
    endtask

    task automatic check_reg(input string name, input arch_reg_t exp, input arch_reg_t act);
        if (act !== exp) begin
            $display("ERR %s expected x%0d actual x%0d", name, exp, act);
            fail_now("register number mismatch");
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            fail_now("result value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            fail_now("status flag mismatch");
        end
    endtask

    task automatic add_row(input logic [1:0] dv, input arch_reg_t rd0, input arch_reg_t rs0,
                           input arch_reg_t rd1, input arch_reg_t rs1, input logic [1:0] wv,
                           input rob_id_t w0, input rob_id_t w1, input data_t v0,
                           input data_t v1, input logic cr, input string name);
        rows.push_back({dv, rd0, rs0, rd1, rs1, wv, w0, w1, v0, v1, cr});
        names.push_back(name);
    endtask

    // drive one row after the edge and check mid-cycle before advancing the model
    task automatic run_cycle(input row_t r, input string name);
        logic      exp_ready;
        logic      exp_busy;
        logic [1:0] acc;
        logic [1:0] exp_cv;
        rob_id_t   exp_tag;
        rob_id_t   id;
        arch_reg_t rs [2];
        arch_reg_t rd [2];
        @(posedge clk);
        #1;
        disp_valid = r.dv;
        disp_rd[0] = r.rd0;
        disp_rd[1] = r.rd1;
        disp_rs1[0] = r.rs0;
        disp_rs1[1] = r.rs1;
        wb_valid = r.wv;
        wb_id[0] = r.w0;
        wb_id[1] = r.w1;
        wb_value[0] = r.v0;
        wb_value[1] = r.v1;
        commit_ready = r.cr;
        #3;
        rs[0] = r.rs0;
        rs[1] = r.rs1;
        rd[0] = r.rd0;
        rd[1] = r.rd1;
        // a group needs two free entries
        exp_ready = (q.size() <= rob_depth - issue_width);
        check_flag({name, " dispatch_ready"}, exp_ready, dispatch_ready);
        check_flag({name, " empty"}, q.size() == 0, empty);
        acc = r.dv & {2{exp_ready}};
        for (int i = 0; i < 2; i++) begin
            if (acc[i]) begin
                check_id({name, " disp_id"}, m_tail + rob_id_t'(i), disp_id[i]);
            end
            exp_busy = m_busy[rs[i]];
            exp_tag = m_tag[rs[i]];
            // slot 1 reads slot 0's fresh entry when it names the same nonzero rd
            if (i == 1 && acc[0] && rd[0] != '0 && rd[0] == rs[1]) begin
                exp_busy = 1'b1;
                exp_tag = m_tail;
            end
            check_flag({name, " src_busy"}, exp_busy, src_busy[i]);
            if (exp_busy) begin
                check_id({name, " src_tag"}, exp_tag, src_tag[i]);
            end
        end
        exp_cv = '0;
        if (r.cr && q.size() > 0) begin
            exp_cv[0] = m_done[q[0]];
        end
        if (exp_cv[0] && q.size() > 1) begin
            exp_cv[1] = m_done[q[1]];
        end
        for (int i = 0; i < 2; i++) begin
            check_flag({name, " commit_valid"}, exp_cv[i], commit_valid[i]);
            if (exp_cv[i]) begin
                check_id({name, " commit_id"}, q[i], commit_id[i]);
                check_reg({name, " commit_rd"}, m_rd[q[i]], commit_rd[i]);
                check_data({name, " commit_value"}, m_value[q[i]], commit_value[i]);
            end
        end
        // retire first and drop busy only for the youngest producer
        for (int i = 0; i < 2; i++) begin
            if (exp_cv[i]) begin
                id = q.pop_front();
                if (m_tag[m_rd[id]] == id) begin
                    m_busy[m_rd[id]] = 1'b0;
                end
            end
        end
        if (r.wv[0]) begin
            m_done[r.w0] = 1'b1;
            m_value[r.w0] = r.v0;
        end
        if (r.wv[1]) begin
            m_done[r.w1] = 1'b1;
            m_value[r.w1] = r.v1;
        end
        // new producers override the clear and slot 1 goes last
        for (int i = 0; i < 2; i++) begin
            if (acc[i]) begin
                q.push_back(m_tail);
                m_rd[m_tail] = rd[i];
                m_done[m_tail] = 1'b0;
                if (rd[i] != '0) begin
                    m_busy[rd[i]] = 1'b1;
                    m_tag[rd[i]] = m_tail;
                end
                m_tail = m_tail + rob_id_t'(1);
            end
        end
    endtask

    // cycle budget
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_now("simulation ran past its cycle limit");
        end
    end

    initial begin
        row_t r;
        int   n;
        void'($urandom(32'hfbd8d515));
        cycles = 0;
        m_tail = '0;
        rst = 1'b1;
        disp_valid = '0;
        wb_valid = '0;
        // a ready core during reset must still see nothing retire
        commit_ready = 1'b1;
        for (int i = 0; i < issue_width; i++) begin
            disp_rd[i] = '0;
            disp_rs1[i] = '0;
            wb_id[i] = '0;
            wb_value[i] = '0;
        end
        // dv, rd0, rs0, rd1, rs1, wv, w0, w1, v0, v1, cr
        add_row(2'b11, 5'd1, 5'd0, 5'd2, 5'd1, 2'b00, 3'd0, 3'd0, 0, 0, 1'b0, "fill_bypass");
        add_row(2'b11, 5'd3, 5'd2, 5'd1, 5'd1, 2'b00, 3'd0, 3'd0, 0, 0, 1'b0, "fill_remap");
        add_row(2'b11, 5'd4, 5'd1, 5'd0, 5'd0, 2'b00, 3'd0, 3'd0, 0, 0, 1'b0, "fill_x0_dest");
        add_row(2'b11, 5'd5, 5'd4, 5'd6, 5'd5, 2'b00, 3'd0, 3'd0, 0, 0, 1'b0, "fill_last");
        add_row(2'b11, 5'd7, 5'd6, 5'd0, 5'd1, 2'b11, 3'd3, 3'd1, 'h33, 'h11, 1'b0, "full_ooo_wb");
        add_row(2'b11, 5'd7, 5'd6, 5'd0, 5'd1, 2'b01, 3'd2, 3'd0, 'h22, 0, 1'b1, "head_not_done");
        add_row(2'b11, 5'd7, 5'd6, 5'd0, 5'd1, 2'b01, 3'd0, 3'd0, 'h10, 0, 1'b1, "head_wb");
        add_row(2'b11, 5'd7, 5'd6, 5'd0, 5'd1, 2'b01, 3'd6, 3'd0, 'h66, 0, 1'b1, "pair_commit");
        add_row(2'b11, 5'd7, 5'd6, 5'd0, 5'd1, 2'b01, 3'd4, 3'd0, 'h44, 0, 1'b1, "refill");
        add_row(2'b00, 5'd0, 5'd0, 5'd0, 5'd0, 2'b01, 3'd5, 3'd0, 'h55, 0, 1'b1, "slot1_blocked");
        add_row(2'b11, 5'd2, 5'd1, 5'd3, 5'd4, 2'b01, 3'd7, 3'd0, 'h77, 0, 1'b1, "busy_cleared");
        add_row(2'b01, 5'd2, 5'd2, 5'd0, 5'd0, 2'b11, 3'd0, 3'd2, 'h100, 'h200, 1'b0, "commit_held");
        add_row(2'b11, 5'd0, 5'd0, 5'd0, 5'd0, 2'b00, 3'd0, 3'd0, 0, 0, 1'b1, "x0_pair");
        cycle_limit = rows.size() * 4 + 200;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        for (int k = 0; k < rows.size(); k++) begin
            run_cycle(rows[k], names[k]);
        end
        // drain writes random results into the oldest unfinished entries
        while (q.size() > 0) begin
            r = '0;
            r.cr = 1'b1;
            n = 0;
            foreach (q[k]) begin
                if (!m_done[q[k]] && n == 0) begin
                    r.wv[0] = 1'b1;
                    r.w0 = q[k];
                    r.v0 = data_t'($urandom);
                    n = 1;
                end else if (!m_done[q[k]] && n == 1) begin
                    r.wv[1] = 1'b1;
                    r.w1 = q[k];
                    r.v1 = data_t'($urandom);
                    n = 2;
                end
            end
            run_cycle(r, "drain");
        end
        // walk all registers two at a time and expect none busy
        for (int k = 0; k < 16; k++) begin
            r = '0;
            r.cr = 1'b1;
            r.rs0 = arch_reg_t'(2 * k);
            r.rs1 = arch_reg_t'(2 * k + 1);
            run_cycle(r, "idle_scan");
            check_flag("idle_scan empty", 1'b1, empty);
            check_flag("idle_scan src_busy0", 1'b0, src_busy[0]);
            check_flag("idle_scan src_busy1", 1'b0, src_busy[1]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rob_tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_tb_clock (
    output logic clk
);
    // 8 ns period, starts low
    initial begin
        clk = 1'b0;
    end

    always begin
        #4 clk = ~clk;
    end

endmodule

`default_nettype wire
